//--- all.f
+incdir+src
src/ecpu_pkg.sv
src/ecpu_prog_mem.sv
src/ecpu_alu.sv
src/ecpu_core_datapath.sv
src/ecpu_core_controller.sv
src/ecpu_top.sv
sim/ecpu_properties.sv
sim/ecpu_tb.sv

//--- sim/ecpu_tb.sv
`include "ecpu_defines.svh"

module ecpu_tb
  import ecpu_pkg::*;
();

  typedef logic [`ECPU_DWIDTH-1:0] word_t;

  localparam int halt_timeout = 2000;   // Cycles.
  localparam int max_instr    = 40;

  logic          clk;
  logic          reset;
  logic          start;
  logic          prog_we;
  ecpu_prog_wr_t prog_wr;
  word_t         a_acc;
  word_t         b_acc;
  ecpu_flags_t   flags;
  logic          retire_valid;
  ecpu_retire_t  retire;
  logic          halted;

  // Reference model state.
  word_t                   prog_words [`ECPU_PROG_DEPTH];
  int                      prog_len;
  logic [`ECPU_AWIDTH-1:0] model_pc;
  word_t                   model_a;
  word_t                   model_b;
  ecpu_flags_t             model_flags;
  logic                    model_done;
  ecpu_retire_t            expected_retire;
  int                      retire_count;
  int                      error_count;

  ecpu_top UUT (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .prog_we      (prog_we),
    .prog_wr      (prog_wr),
    .a_acc        (a_acc),
    .b_acc        (b_acc),
    .flags        (flags),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halted       (halted)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error();
    error_count++;
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flags(input ecpu_flags_t got, input ecpu_flags_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t flags got cvz=%b expected cvz=%b", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_retire(input ecpu_retire_t got, input ecpu_retire_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t retire got dest=%b value=%h cvz=%b alu=%b", $time,
               got.dest, got.value, got.flags, got.is_alu);
      $display("[FAIL] t=%0t retire expected dest=%b value=%h cvz=%b alu=%b", $time,
               exp.dest, exp.value, exp.flags, exp.is_alu);
      stop_on_error();
    end
  endtask

  // Expected ALU result and flags.
  function automatic void alu_model(input word_t a, input word_t b, input logic [3:0] fn,
                                    output word_t y, output ecpu_flags_t f);
    f = '0;
    case (fn)
      ADD:
      begin
        {f.c, y} = {1'b0, a} + {1'b0, b};
        f.v      = (a[15] == b[15]) && (y[15] != a[15]);
      end
      SUB:
      begin
        y   = a - b;
        f.c = (a < b);   // Borrow.
        f.v = (a[15] != b[15]) && (y[15] != a[15]);
      end
      AND:    y = a & b;
      OR:     y = a | b;
      XOR:    y = a ^ b;
      NOT_A:  y = ~a;
      SHL:
      begin
        y   = a << 1;
        f.c = a[15];
      end
      SHR:
      begin
        y   = a >> 1;
        f.c = a[0];
      end
      INC:
      begin
        y   = a + 16'd1;
        f.c = (a == 16'hffff);
        f.v = (a == 16'h7fff);
      end
      DEC:
      begin
        y   = a - 16'd1;
        f.c = (a == 16'h0000);
        f.v = (a == 16'h8000);
      end
      PASS_B: y = b;
      default: y = a;
    endcase
    f.z = (y == 16'h0000);
  endfunction

  function automatic word_t fetch_word();
    fetch_word = prog_words[model_pc];
    model_pc   = model_pc + 1'b1;
  endfunction

  // Steps the model up to the next retiring instruction; sets model_done at HALT.
  function automatic ecpu_retire_t next_retire();
    word_t        word;
    word_t        opa;
    word_t        opb;
    word_t        res;
    ecpu_flags_t  f;
    ecpu_retire_t r;
    logic         found;
    r     = '0;
    found = 1'b0;
    while (!model_done && !found)
    begin
      word = fetch_word();
      case (word[15:12])
        KIND_LDA, KIND_LDB:
        begin
          opa   = fetch_word();
          r     = '{dest: (word[15:12] == KIND_LDB), value: opa, flags: model_flags, is_alu: 1'b0};
          found = 1'b1;
        end
        KIND_ALU:
        begin
          opa = word[5] ? model_a : fetch_word();
          opb = word[6] ? model_b : fetch_word();
          alu_model(opa, opb, word[3:0], res, f);
          model_flags = f;
          r     = '{dest: word[4], value: res, flags: f, is_alu: 1'b1};
          found = 1'b1;
        end
        KIND_HALT: model_done = 1'b1;
        default: ;   // NOP and undefined kinds.
      endcase
      if (found && r.dest)
        model_b = r.value;
      else if (found)
        model_a = r.value;
    end
    return r;
  endfunction

  function automatic word_t pick_value();
    case ($urandom % 6)
      0: return 16'h0000;
      1: return 16'h0001;
      2: return 16'h7fff;
      3: return 16'h8000;
      4: return 16'hffff;
      default: return word_t'($urandom);
    endcase
  endfunction

  function automatic void put_word(input word_t w);
    prog_words[prog_len] = w;
    prog_len++;
  endfunction

  // Directed programs open with all sixteen functions on streamed operands.
  task automatic build_program(input logic directed);
    int         n_instr;
    int         pick;
    logic [3:0] fn;
    logic       src_a;
    logic       src_b;
    prog_len = 0;
    n_instr  = directed ? max_instr : 1 + $urandom % max_instr;
    for (int i = 0; i < n_instr - 1; i++)
    begin
      pick  = $urandom % 8;
      fn    = 4'($urandom);
      src_a = 1'($urandom);
      src_b = 1'($urandom);
      if (directed && i < 16)
      begin
        pick  = 4;
        fn    = 4'(i);
        src_a = 1'b0;
        src_b = 1'b0;
      end
      case (pick)
        0: put_word({KIND_NOP, 12'($urandom)});
        1: put_word({4'(5 + $urandom % 11), 12'($urandom)});   // Undefined kind.
        2,
        3:
        begin
          put_word({(pick == 2) ? KIND_LDA : KIND_LDB, 12'h000});
          put_word(pick_value());
        end
        default:
        begin
          put_word({KIND_ALU, 5'h00, src_b, src_a, 1'($urandom), fn});
          if (!src_a)
            put_word(pick_value());
          if (!src_b)
            put_word(pick_value());
        end
      endcase
    end
    put_word({KIND_HALT, 12'h000});
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++)
    begin
      @(posedge clk);
      #1;
      prog_we = 1'b1;
      prog_wr = '{addr: `ECPU_AWIDTH'(i), data: prog_words[i]};
    end
    @(posedge clk);
    #1;
    prog_we = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_halted();
    int cycles;
    cycles = 0;
    while (halted !== 1'b1)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > halt_timeout)
      begin
        $display("Timeout: core did not halt within %0d cycles", halt_timeout);
        stop_on_error();
      end
    end
  endtask

  task automatic run_program(input logic directed);
    apply_reset();
    model_pc     = '0;
    model_a      = '0;
    model_b      = '0;
    model_flags  = '0;
    model_done   = 1'b0;
    retire_count = 0;
    @(negedge clk);
    check_word("a_acc", a_acc, '0);
    check_word("b_acc", b_acc, '0);
    check_flags(flags, '0);
    if (halted !== 1'b0 || retire_valid !== 1'b0)
    begin
      $display("Core not idle after reset at time %0t", $time);
      stop_on_error();
    end
    build_program(directed);
    load_program();
    pulse_start();
    wait_halted();
    repeat (8) @(negedge clk);
    if (halted !== 1'b1)
    begin
      $display("halted dropped without a reset at time %0t", $time);
      stop_on_error();
    end
    void'(next_retire());
    if (!model_done)
    begin
      $display("Core halted before the program's HALT word, %0d retired", retire_count);
      stop_on_error();
    end
    check_word("a_acc", a_acc, model_a);
    check_word("b_acc", b_acc, model_b);
    check_flags(flags, model_flags);
    $display("Program of %0d words ran, %0d instructions retired", prog_len, retire_count);
  endtask

  // Compares every retire pulse against the model.
  always @(negedge clk)
  begin
    if (reset === 1'b0 && retire_valid === 1'b1)
    begin
      expected_retire = next_retire();
      if (model_done)
      begin
        $display("Retire pulse at time %0t after the last instruction", $time);
        stop_on_error();
      end
      check_retire(retire, expected_retire);
      retire_count++;
    end
  end

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    prog_we      = 1'b0;
    prog_wr      = '0;
    error_count  = 0;
    retire_count = 0;
    model_done   = 1'b1;
    void'($urandom(83));
    run_program(1'b1);
    repeat (3)
      run_program(1'b0);
    if (error_count == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
      stop_on_error();
  end

endmodule

//--- sim/ecpu_properties.sv
module ecpu_properties
(
  input logic clk,
  input logic reset,
  input logic rom_req,
  input logic rom_grant,
  input logic read_alu,
  input logic load_alu,
  input logic load_alu_b,
  input logic load_a_acc,
  input logic load_b_acc,
  input logic load_imm,
  input logic exec,
  input logic retire_valid,
  input logic halted
);

  // Grant only in the cycle after a request.
  grant_after_req: assert property (@(posedge clk) disable iff (reset)
    rom_grant |-> $past(rom_req))
    else $error("rom_grant without a request in the previous cycle");

  // One fetch in flight at a time.
  single_req: assert property (@(posedge clk) disable iff (reset)
    rom_req |=> !rom_req)
    else $error("rom_req held for two cycles");

  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    $onehot0({read_alu, load_alu, load_alu_b, load_a_acc, load_b_acc, load_imm, exec}))
    else $error("more than one datapath strobe active");

  no_retire_halted: assert property (@(posedge clk) disable iff (reset)
    !(retire_valid && halted))
    else $error("retire_valid while halted");

endmodule

bind ecpu_top ecpu_properties u_properties (
  .clk          (clk),
  .reset        (reset),
  .rom_req      (rom_req),
  .rom_grant    (rom_grant),
  .read_alu     (read_alu),
  .load_alu     (load_alu),
  .load_alu_b   (load_alu_b),
  .load_a_acc   (load_a_acc),
  .load_b_acc   (load_b_acc),
  .load_imm     (load_imm),
  .exec         (exec),
  .retire_valid (retire_valid),
  .halted       (halted)
);

//--- src/ecpu_top.sv
`include "ecpu_defines.svh"

module ecpu_top
  import ecpu_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    prog_we,
  input  ecpu_prog_wr_t           prog_wr,
  output logic [`ECPU_DWIDTH-1:0] a_acc,
  output logic [`ECPU_DWIDTH-1:0] b_acc,
  output ecpu_flags_t             flags,
  output logic                    retire_valid,
  output ecpu_retire_t            retire,
  output logic                    halted
);

  logic                    rom_req;
  logic                    rom_grant;
  logic [`ECPU_AWIDTH-1:0] rom_addr;
  logic [`ECPU_DWIDTH-1:0] rom_data;
  logic                    read_alu;
  logic                    load_alu;
  logic                    load_alu_b;
  logic                    load_a_acc;
  logic                    load_b_acc;
  logic                    load_imm;
  logic                    imm_dest;
  logic                    exec;
  logic [`ECPU_DWIDTH-1:0] a;
  logic [`ECPU_DWIDTH-1:0] b;
  logic [`ECPU_DWIDTH-1:0] y;
  ecpu_alu_op_e            op;
  ecpu_flags_t             alu_flags;

  assign flags = retire.flags;   // Current flags ride in the retire record.

  ecpu_prog_mem u_prog_mem (.*);

  ecpu_core_controller u_controller (.*);

  ecpu_core_datapath u_datapath (.*);

  ecpu_alu u_alu (.a(a), .b(b), .op(op), .y(y), .flags(alu_flags));

endmodule

//--- src/ecpu_core_controller.sv
`include "ecpu_defines.svh"

module ecpu_core_controller
  import ecpu_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    rom_grant,
  input  logic [`ECPU_DWIDTH-1:0] rom_data,
  output logic                    rom_req,
  output logic [`ECPU_AWIDTH-1:0] rom_addr,
  output logic                    read_alu,
  output logic                    load_alu,
  output logic                    load_alu_b,
  output logic                    load_a_acc,
  output logic                    load_b_acc,
  output logic                    load_imm,
  output logic                    imm_dest,
  output logic                    exec,
  output logic                    halted
);

  ecpu_state_e             state;
  ecpu_state_e             state_next;
  ecpu_kind_e              kind;
  logic [`ECPU_AWIDTH-1:0] pc;
  logic                    src_a_acc;
  logic                    src_b_acc;

  assign kind     = ecpu_kind_e'(rom_data[`ECPU_KIND_MSB:`ECPU_KIND_LSB]);
  assign rom_addr = pc;
  assign halted   = (state == HALTED);

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:      if (start) state_next = FETCH_OP;
      FETCH_OP:  state_next = WAIT_OP;
      WAIT_OP:
        if (rom_grant)
        begin
          case (kind)
            KIND_LDA, KIND_LDB: state_next = FETCH_IMM;
            KIND_ALU:           state_next = FETCH_A;
            KIND_HALT:          state_next = HALTED;
            default:            state_next = FETCH_OP;   // NOP and undefined kinds.
          endcase
        end
      FETCH_A:   state_next = src_a_acc ? FETCH_B : WAIT_A;
      WAIT_A:    if (rom_grant) state_next = FETCH_B;
      FETCH_B:   state_next = src_b_acc ? EXECUTE : WAIT_B;
      WAIT_B:    if (rom_grant) state_next = EXECUTE;
      FETCH_IMM: state_next = WAIT_IMM;
      WAIT_IMM:  if (rom_grant) state_next = FETCH_OP;
      EXECUTE:   state_next = FETCH_OP;
      HALTED:    state_next = HALTED;   // Left only by reset.
      default:   state_next = IDLE;
    endcase
  end

  // An accumulator operand skips its fetch.
  always_comb
  begin
    rom_req    = (state == FETCH_OP) || (state == FETCH_IMM) ||
                 ((state == FETCH_A) && !src_a_acc) ||
                 ((state == FETCH_B) && !src_b_acc);
    read_alu   = (state == WAIT_OP) && rom_grant && (kind == KIND_ALU);
    load_alu   = (state == WAIT_A) && rom_grant;
    load_a_acc = (state == FETCH_A) && src_a_acc;
    load_alu_b = (state == WAIT_B) && rom_grant;
    load_b_acc = (state == FETCH_B) && src_b_acc;
    load_imm   = (state == WAIT_IMM) && rom_grant;
    exec       = (state == EXECUTE);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= IDLE;
      pc        <= '0;
      src_a_acc <= 1'b0;
      src_b_acc <= 1'b0;
      imm_dest  <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (rom_grant)
        pc <= pc + 1'b1;   // Wraps at the end of memory.
      // Decode fields kept for the rest of the instruction.
      if ((state == WAIT_OP) && rom_grant)
      begin
        src_a_acc <= rom_data[`ECPU_SRC_A_BIT];
        src_b_acc <= rom_data[`ECPU_SRC_B_BIT];
        imm_dest  <= (kind == KIND_LDB);
      end
    end
  end

endmodule

//--- src/ecpu_core_datapath.sv
`include "ecpu_defines.svh"

module ecpu_core_datapath
  import ecpu_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`ECPU_DWIDTH-1:0] rom_data,
  input  logic                    read_alu,
  input  logic                    load_alu,
  input  logic                    load_alu_b,
  input  logic                    load_a_acc,
  input  logic                    load_b_acc,
  input  logic                    load_imm,
  input  logic                    imm_dest,
  input  logic                    exec,
  input  logic [`ECPU_DWIDTH-1:0] y,
  input  ecpu_flags_t             alu_flags,
  output logic [`ECPU_DWIDTH-1:0] a,
  output logic [`ECPU_DWIDTH-1:0] b,
  output ecpu_alu_op_e            op,
  output logic [`ECPU_DWIDTH-1:0] a_acc,
  output logic [`ECPU_DWIDTH-1:0] b_acc,
  output logic                    retire_valid,
  output ecpu_retire_t            retire
);

  logic        dest;
  ecpu_flags_t flags_q;

  // Operand and function latches, filled strobe by strobe.
  always_ff @(posedge clk)
  begin
    if (load_alu)
      a <= rom_data;
    else if (load_a_acc)
      a <= a_acc;
    if (load_alu_b)
      b <= rom_data;
    else if (load_b_acc)
      b <= b_acc;
    if (read_alu)
    begin
      op   <= ecpu_alu_op_e'(rom_data[`ECPU_FUNC_MSB:`ECPU_FUNC_LSB]);
      dest <= rom_data[`ECPU_DEST_BIT];
    end
  end

  // Accumulators and flags.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      a_acc   <= '0;
      b_acc   <= '0;
      flags_q <= '0;
    end
    else if (load_imm)
    begin
      if (imm_dest)
        b_acc <= rom_data;
      else
        a_acc <= rom_data;
    end
    else if (exec)
    begin
      if (dest)
        b_acc <= y;
      else
        a_acc <= y;
      flags_q <= alu_flags;
    end
  end

  // Retire record holds until the next instruction.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      retire_valid <= 1'b0;
      retire       <= '0;
    end
    else
    begin
      retire_valid <= load_imm | exec;
      if (load_imm)
        retire <= '{dest: imm_dest, value: rom_data, flags: flags_q, is_alu: 1'b0};
      else if (exec)
        retire <= '{dest: dest, value: y, flags: alu_flags, is_alu: 1'b1};
    end
  end

endmodule

//--- src/ecpu_alu.sv
`include "ecpu_defines.svh"

module ecpu_alu
  import ecpu_pkg::*;
(
  input  logic [`ECPU_DWIDTH-1:0] a,
  input  logic [`ECPU_DWIDTH-1:0] b,
  input  ecpu_alu_op_e            op,
  output logic [`ECPU_DWIDTH-1:0] y,
  output ecpu_flags_t             flags
);

  logic [`ECPU_DWIDTH-1:0] rhs;
  logic [`ECPU_DWIDTH:0]   sum;
  logic                    sub;
  logic                    carry;
  logic                    ovf;
  logic                    add_ovf;
  logic                    sub_ovf;

  // INC and DEC reuse the adder with a constant one.
  assign sub = (op == SUB) || (op == DEC);
  assign rhs = ((op == INC) || (op == DEC)) ? `ECPU_DWIDTH'(1) : b;

  // Top bit is carry out, or borrow for subtraction.
  assign sum = sub ? ({1'b0, a} - {1'b0, rhs})
                   : ({1'b0, a} + {1'b0, rhs});

  // Signed overflow.
  assign add_ovf = (a[`ECPU_DWIDTH-1] == rhs[`ECPU_DWIDTH-1]) &&
                   (sum[`ECPU_DWIDTH-1] != a[`ECPU_DWIDTH-1]);
  assign sub_ovf = (a[`ECPU_DWIDTH-1] != rhs[`ECPU_DWIDTH-1]) &&
                   (sum[`ECPU_DWIDTH-1] != a[`ECPU_DWIDTH-1]);

  always_comb
  begin
    y     = a;
    carry = 1'b0;
    ovf   = 1'b0;
    case (op)
      ADD, INC:
      begin
        y     = sum[`ECPU_DWIDTH-1:0];
        carry = sum[`ECPU_DWIDTH];
        ovf   = add_ovf;
      end
      SUB, DEC:
      begin
        y     = sum[`ECPU_DWIDTH-1:0];
        carry = sum[`ECPU_DWIDTH];
        ovf   = sub_ovf;
      end
      AND:    y = a & b;
      OR:     y = a | b;
      XOR:    y = a ^ b;
      NOT_A:  y = ~a;
      SHL:
      begin
        y     = {a[`ECPU_DWIDTH-2:0], 1'b0};
        carry = a[`ECPU_DWIDTH-1];   // Bit shifted out.
      end
      SHR:
      begin
        y     = {1'b0, a[`ECPU_DWIDTH-1:1]};
        carry = a[0];
      end
      PASS_B: y = b;
      default: y = a;   // PASS_A and unused codes.
    endcase
  end

  assign flags = '{c: carry, v: ovf, z: (y == '0)};

endmodule

//--- src/ecpu_prog_mem.sv
`include "ecpu_defines.svh"

module ecpu_prog_mem
  import ecpu_pkg::*;
(
  input  logic                    clk,
  input  logic                    prog_we,
  input  ecpu_prog_wr_t           prog_wr,
  input  logic                    rom_req,
  input  logic [`ECPU_AWIDTH-1:0] rom_addr,
  output logic                    rom_grant,
  output logic [`ECPU_DWIDTH-1:0] rom_data
);

  logic [`ECPU_DWIDTH-1:0] mem [`ECPU_PROG_DEPTH];

  // Load port for writes while the core is idle.
  always_ff @(posedge clk)
  begin
    if (prog_we)
      mem[prog_wr.addr] <= prog_wr.data;
  end

  // Registered read.
  always_ff @(posedge clk)
  begin
    if (rom_req)
      rom_data <= mem[rom_addr];
  end

  // Grant is the request one cycle late.
  always_ff @(posedge clk)
  begin
    rom_grant <= rom_req;
  end

endmodule

//--- src/ecpu_pkg.sv
`include "ecpu_defines.svh"

package ecpu_pkg;

  typedef enum logic [`ECPU_KIND_MSB-`ECPU_KIND_LSB:0] {
    KIND_NOP  = 4'h0,
    KIND_LDA  = 4'h1,
    KIND_LDB  = 4'h2,
    KIND_ALU  = 4'h3,
    KIND_HALT = 4'h4
  } ecpu_kind_e;

  // Codes 12 to 15 fall back to PASS_A.
  typedef enum logic [`ECPU_OPWIDTH-1:0] {
    ADD    = 4'h0,
    SUB    = 4'h1,
    AND    = 4'h2,
    OR     = 4'h3,
    XOR    = 4'h4,
    NOT_A  = 4'h5,
    SHL    = 4'h6,
    SHR    = 4'h7,
    INC    = 4'h8,
    DEC    = 4'h9,
    PASS_A = 4'hA,
    PASS_B = 4'hB
  } ecpu_alu_op_e;

  typedef enum logic [3:0] {
    IDLE, FETCH_OP, WAIT_OP, FETCH_A, WAIT_A, FETCH_B, WAIT_B,
    FETCH_IMM, WAIT_IMM, EXECUTE, HALTED
  } ecpu_state_e;

  typedef struct packed {
    logic c;
    logic v;
    logic z;
  } ecpu_flags_t;

  typedef struct packed {
    logic                    dest;   // 1 for B_ACC.
    logic [`ECPU_DWIDTH-1:0] value;
    ecpu_flags_t             flags;
    logic                    is_alu;
  } ecpu_retire_t;

  typedef struct packed {
    logic [`ECPU_AWIDTH-1:0] addr;
    logic [`ECPU_DWIDTH-1:0] data;
  } ecpu_prog_wr_t;

endpackage

//--- src/ecpu_defines.svh
`ifndef ECPU_DEFINES_SVH
`define ECPU_DEFINES_SVH

// Word and address sizes.
`define ECPU_DWIDTH      16
`define ECPU_AWIDTH      8
`define ECPU_PROG_DEPTH  256
`define ECPU_OPWIDTH     4

// Instruction kind field.
`define ECPU_KIND_MSB    15
`define ECPU_KIND_LSB    12

// ALU instruction source and destination bits.
`define ECPU_SRC_B_BIT   6   // 1 takes B_ACC as operand B.
`define ECPU_SRC_A_BIT   5   // 1 takes A_ACC as operand A.
`define ECPU_DEST_BIT    4   // 0 is A_ACC, 1 is B_ACC.

// ALU function field.
`define ECPU_FUNC_MSB    3
`define ECPU_FUNC_LSB    0

`endif
